// ==== dv/avl_stim.txt ====
# op address data byteenable expected burst test
# burst 1 means no idle cycle before the transfer, expected is unused on writes
W 00000010 cafef00d f 00000000 0 low_word
R 00000010 00000000 f cafef00d 0 low_word
W bfbe0008 a5a50023 f 00000000 0 alias_br_back
W bfc20000 5a5a0032 f 00000000 0 alias_br_fwd
W b4000000 0f0f0042 f 00000000 0 alias_jump
W bfc00f64 f0f00021 f 00000000 0 alias_reset
R bfc00f6c 00000000 f a5a50023 0 alias_br_back
R bfc00f90 00000000 f 5a5a0032 0 alias_br_fwd
R bfc00fb8 00000000 f 0f0f0042 0 alias_jump
R bfbe0000 00000000 f f0f00021 0 alias_reset
W 00000020 11223344 f 00000000 0 byte_enable
W 00000020 aabbccdd 5 00000000 0 byte_enable
W 00000021 99000000 8 00000000 0 byte_enable
R 00000020 00000000 f 99bb33dd 0 byte_enable
W 00000030 00000001 f 00000000 0 posted_writes
W 00000030 00000002 f 00000000 1 posted_writes
W 00000032 00000003 f 00000000 1 posted_writes
R 00000030 00000000 f 00000003 1 posted_writes
W 12345f24 76543210 f 00000000 0 reset_wrap
R 00000017 00000000 f 76543210 0 reset_wrap

// ==== project.f ====
+incdir+source
source/mem_map_pkg.sv
source/stage_if.sv
source/avl_req_capture.sv
source/window_translate.sv
source/sparse_mem_array.sv
source/avl_sparse_mem.sv
dv/avl_sparse_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module avl_sparse_mem_tb -o avl_sparse_mem_sim

./obj_dir/avl_sparse_mem_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0

// ==== dv/avl_sparse_mem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module avl_sparse_mem_tb;

	localparam int MAX_OPS = 64;

	logic        clk;
	logic        arst_n;
	logic [31:0] address;
	logic        read;
	logic        write;
	logic [31:0] writedata;
	logic [3:0]  byteenable;
	logic        waitrequest;
	logic [31:0] readdata;

	// one entry per transfer line of the stim file
	bit          rd_tab    [MAX_OPS];
	logic [31:0] addr_tab  [MAX_OPS];
	logic [31:0] data_tab  [MAX_OPS];
	logic [3:0]  be_tab    [MAX_OPS];
	logic [31:0] exp_tab   [MAX_OPS];
	bit          burst_tab [MAX_OPS];
	string       name_tab  [MAX_OPS];

	int n_ops = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	avl_sparse_mem u_avl_sparse_mem (
		.clk         (clk),
		.arst_n      (arst_n),
		.address     (address),
		.read        (read),
		.write       (write),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.waitrequest (waitrequest),
		.readdata    (readdata)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// watchdog, limit set once the stim file is parsed
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the transfers did not finish", cycle_cnt);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// parse op, address, data, byteenable, expected word, burst flag, test name
	task automatic load_stim();
		int          fd;
		int          n;
		int          burst;
		string       line;
		string       op_s;
		string       name;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [3:0]  be;
		fd = $fopen("dv/avl_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/avl_stim.txt");
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// skip blank and comment lines
			if (n > 2 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s %h %h %h %h %d %s", op_s, a, d, be, e, burst, name);
				if (n == 7 && n_ops < MAX_OPS) begin
					rd_tab[n_ops]    = (op_s == "R");
					addr_tab[n_ops]  = a;
					data_tab[n_ops]  = d;
					be_tab[n_ops]    = be;
					exp_tab[n_ops]   = e;
					burst_tab[n_ops] = (burst != 0);
					name_tab[n_ops]  = name;
					n_ops++;
				end
			end
		end
		$fclose(fd);
	endtask

	// posted write, must never see waitrequest
	task automatic avalon_write(int i);
		address    = addr_tab[i];
		writedata  = data_tab[i];
		byteenable = be_tab[i];
		write      = 1'b1;
		@(negedge clk);
		check_cnt++;
		assert (waitrequest === 1'b0) else begin
			err_cnt++;
			$display("waitrequest was high during write of test %s", name_tab[i]);
		end
		@(posedge clk);
		#2;
		write = 1'b0;
	endtask

	// read held until waitrequest drops, then data and stall length checked
	task automatic avalon_read(int i);
		int waits;
		waits      = 0;
		address    = addr_tab[i];
		byteenable = be_tab[i];
		read       = 1'b1;
		// sample mid-cycle where the outputs have settled
		@(negedge clk);
		while (waitrequest !== 1'b0) begin
			waits++;
			@(negedge clk);
		end
		check_cnt += 2;
		assert (readdata === exp_tab[i]) else begin
			err_cnt++;
			$display("Fail %s expected %h actual %h", name_tab[i], exp_tab[i], readdata);
		end
		assert (waits == 3) else begin
			err_cnt++;
			$display("Fail %s wait cycles expected %0d actual %0d", name_tab[i], 3, waits);
		end
		@(posedge clk);
		#2;
		read = 1'b0;
	endtask

	initial begin
		int gap;
		arst_n     = 1'b0;
		address    = 32'h0;
		read       = 1'b0;
		write      = 1'b0;
		writedata  = 32'h0;
		byteenable = 4'h0;
		void'($urandom(37));
		load_stim();
		if (n_ops == 0) begin
			$display("no transfers were read from the stimulus file");
			err_cnt++;
		end
		cycle_limit = n_ops * 8 + 50;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		@(posedge clk);
		#2;
		for (int i = 0; i < n_ops; i++) begin
			// burst lines follow the previous transfer with no idle cycle
			if (!burst_tab[i]) begin
				gap = $urandom % 3;
				repeat (gap) begin
					@(posedge clk);
					#2;
				end
			end
			if (rd_tab[i]) begin
				avalon_read(i);
			end else begin
				avalon_write(i);
			end
		end
		repeat (4) @(posedge clk);
		$display("transfers %0d checks %0d errors %0d", n_ops, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/avl_sparse_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module avl_sparse_mem
	import mem_map_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] address,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	input  logic [3:0]  byteenable,
	output logic        waitrequest,
	output logic [31:0] readdata
);

	// capture to translate carries the raw request
	stage_if #(.payload_t(mem_req_t)) u_s1_s2 ();
	// translate to array carries the folded op
	stage_if #(.payload_t(mem_op_t)) u_s2_s3 ();

	avl_req_capture u_req_capture (
		.clk         (clk),
		.arst_n      (arst_n),
		.address     (address),
		.read        (read),
		.write       (write),
		.writedata   (writedata),
		.byteenable  (byteenable),
		.waitrequest (waitrequest),
		.readdata    (readdata),
		.down        (u_s1_s2.producer)
	);

	window_translate u_window_translate (
		.clk    (clk),
		.arst_n (arst_n),
		.up     (u_s1_s2.consumer),
		.down   (u_s2_s3.producer)
	);

	sparse_mem_array u_mem_array (
		.clk    (clk),
		.arst_n (arst_n),
		.up     (u_s2_s3.consumer)
	);

endmodule

`default_nettype wire

// ==== source/sparse_mem_array.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_map_cfg.svh"

module sparse_mem_array
	import mem_map_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	stage_if.consumer up
);

	// contents start unknown and only fill through writes
	logic [31:0] mem [`MEM_DEPTH];

	mem_op_t op;
	logic    wr_en;
	logic    rd_en;

	assign op    = up.payload;
	assign wr_en = up.valid & op.is_write;
	assign rd_en = up.valid & ~op.is_write;

	// byte lane writes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (op.byteenable[b]) begin
					mem[op.idx][8*b +: 8] <= op.wdata[8*b +: 8];
				end
			end
		end
	end

	// registered read word, held until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			up.rd_data <= mem[op.idx];
		end
	end

	// one-cycle done pulse lines up with rd_data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			up.rd_done <= 1'b0;
		end else begin
			up.rd_done <= rd_en;
		end
	end

endmodule

`default_nettype wire

// ==== source/window_translate.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_map_cfg.svh"

module window_translate
	import mem_map_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	stage_if.consumer up,
	stage_if.producer down
);

	// window bases, sums wrap at 32 bits like the cpu adder
	localparam logic [31:0] BR_BACK_BASE = `RESET_VECTOR + `BRANCH_MIN_SPAN;
	localparam logic [31:0] BR_FWD_BASE  = `RESET_VECTOR + `BRANCH_MAX_SPAN;
	localparam logic [31:0] JUMP_BASE    = `JUMP_MAX_ADDR;
	localparam logic [31:0] WIN_BYTES    = `WINDOW_WORDS * 4;
	localparam logic [31:0] LOW_LIMIT    = `LOW_LIMIT_IDX;

	localparam logic [`MEM_IDX_W-1:0] BR_BACK_IDX = `MEM_IDX_W'(`BR_BACK_OFFSET);
	localparam logic [`MEM_IDX_W-1:0] BR_FWD_IDX  = `MEM_IDX_W'(`BR_FWD_OFFSET);
	localparam logic [`MEM_IDX_W-1:0] JUMP_IDX    = `MEM_IDX_W'(`JUMP_OFFSET);
	localparam logic [`MEM_IDX_W-1:0] RESET_IDX   = `MEM_IDX_W'(`RESET_OFFSET);

	mem_req_t              req;
	mem_op_t               op_c;
	win_e                  win_c;
	logic [`MEM_IDX_W-1:0] idx_c;

	// byte distance from each window base
	logic [31:0] d_back;
	logic [31:0] d_fwd;
	logic [31:0] d_jump;
	logic [31:0] d_rst;

	assign req = up.payload;

	assign d_back = req.addr - BR_BACK_BASE;
	assign d_fwd  = req.addr - BR_FWD_BASE;
	assign d_jump = req.addr - JUMP_BASE;
	assign d_rst  = req.addr - `RESET_VECTOR;

	// windows checked in priority order, low bits of the address dropped
	// a distance below WIN_BYTES means base <= addr < base + WIN_BYTES
	always_comb begin
		win_c = WIN_RESET;
		// fallback wraps around the array
		idx_c = d_rst[`MEM_IDX_W+1:2] + RESET_IDX;
		if ((req.addr >> 2) <= LOW_LIMIT) begin
			win_c = WIN_LOW;
			idx_c = req.addr[`MEM_IDX_W+1:2];
		end else if (d_back < WIN_BYTES) begin
			win_c = WIN_BR_BACK;
			idx_c = d_back[`MEM_IDX_W+1:2] + BR_BACK_IDX;
		end else if (d_fwd < WIN_BYTES) begin
			win_c = WIN_BR_FWD;
			idx_c = d_fwd[`MEM_IDX_W+1:2] + BR_FWD_IDX;
		end else if (d_jump < WIN_BYTES) begin
			win_c = WIN_JUMP;
			idx_c = d_jump[`MEM_IDX_W+1:2] + JUMP_IDX;
		end
	end

	always_comb begin
		op_c.is_write   = req.is_write;
		op_c.idx        = idx_c;
		op_c.wdata      = req.wdata;
		op_c.byteenable = req.byteenable;
		op_c.win        = win_c;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			down.valid <= 1'b0;
		end else begin
			down.valid <= up.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (up.valid) begin
			down.payload <= op_c;
		end
	end

	// read return goes straight back to stage 1
	assign up.rd_done = down.rd_done;
	assign up.rd_data = down.rd_data;

endmodule

`default_nettype wire

// ==== source/avl_req_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module avl_req_capture
	import mem_map_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] address,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	input  logic [3:0]  byteenable,
	output logic        waitrequest,
	output logic [31:0] readdata,
	stage_if.producer   down
);

	// set once a read has gone down the pipe, cleared by its return
	logic     rd_pending;
	// first cycle of a read the master has just raised
	logic     new_read;
	// push an item into stage 2 at this edge
	logic     issue;
	mem_req_t req_c;

	// write wins if the master ever raises both
	assign new_read = read & ~write & ~rd_pending;
	assign issue    = write | new_read;

	always_comb begin
		req_c.is_write   = write;
		req_c.addr       = address;
		req_c.wdata      = writedata;
		req_c.byteenable = byteenable;
	end

	// writes are posted so they never stall
	// a read stalls from its first cycle until the array answers
	assign waitrequest = (new_read | rd_pending) & ~down.rd_done;

	// data is only meaningful in the completing cycle
	assign readdata = down.rd_done ? down.rd_data : 32'h0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending <= 1'b0;
		end else if (down.rd_done) begin
			rd_pending <= 1'b0;
		end else if (new_read) begin
			rd_pending <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			down.valid <= 1'b0;
		end else begin
			down.valid <= issue;
		end
	end

	// payload only loads with a new item
	always_ff @(posedge clk) begin
		if (issue) begin
			down.payload <= req_c;
		end
	end

endmodule

`default_nettype wire

// ==== source/stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface stage_if #(
	parameter type payload_t = logic [31:0]
) ();

	// one-cycle strobe per item, no back-pressure
	logic        valid;
	payload_t    payload;

	// read return, only used on the path back from the array
	logic        rd_done;
	logic [31:0] rd_data;

	// upstream side
	modport producer (
		output valid,
		output payload,
		input  rd_done,
		input  rd_data
	);

	// downstream side
	modport consumer (
		input  valid,
		input  payload,
		output rd_done,
		output rd_data
	);

endinterface

`default_nettype wire

// ==== source/mem_map_pkg.sv ====
`default_nettype none

`include "mem_map_cfg.svh"

package mem_map_pkg;

	// which address window a request fell into
	typedef enum logic [2:0] {
		WIN_LOW,
		WIN_BR_BACK,
		WIN_BR_FWD,
		WIN_JUMP,
		WIN_RESET
	} win_e;

	// raw avalon request as captured by stage 1
	typedef struct packed {
		logic        is_write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  byteenable;
	} mem_req_t;

	// translated request handed to the array
	typedef struct packed {
		logic                  is_write;
		// word index into the array
		logic [`MEM_IDX_W-1:0] idx;
		logic [31:0]           wdata;
		logic [3:0]            byteenable;
		// kept for waveform debug
		win_e                  win;
	} mem_op_t;

endpackage

`default_nettype wire

// ==== source/mem_map_cfg.svh ====
`ifndef MEM_MAP_CFG_SVH
`define MEM_MAP_CFG_SVH

// array geometry
`define MEM_DEPTH 1024
`define MEM_IDX_W 10

// mips reset vector in kseg1
`define RESET_VECTOR 32'hbfc00000

// largest forward branch reach in bytes
`define BRANCH_MAX_SPAN 32'h0001fffc
// largest backward branch reach, two's complement of the byte span
`define BRANCH_MIN_SPAN 32'hfffe0000

// base of the far jump window
`define JUMP_MAX_ADDR 32'hb3fffffc

// each far window covers this many words
`define WINDOW_WORDS 10

// word addresses up to here map straight onto the array
`define LOW_LIMIT_IDX 20

// index bases of the folded windows
`define BR_BACK_OFFSET 21
`define BR_FWD_OFFSET 31
`define JUMP_OFFSET 41
`define RESET_OFFSET 60

`endif
